// File: source/aha_soc_pkg.sv
/* Platform controller shared definitions: APB widths, register map,
   reset values and the pad drive-strength code type */
`default_nettype none

package aha_soc_pkg;

  // APB register port
  localparam int apb_addr_width = 12;
  localparam int apb_data_width = 32;

  // Output pad drive-strength groups
  localparam int num_pad_groups = 8;
  localparam int pad_ds_width   = 3;

  typedef logic [pad_ds_width-1:0] pad_ds_t;

  localparam pad_ds_t pad_ds_reset = 3'd4;

  // Reset domains
  localparam int num_domains = 4;
  localparam int dom_cpu     = 0;
  localparam int dom_periph  = 1;
  localparam int dom_tlx     = 2;
  localparam int dom_cgra    = 3;

  // Peripheral clock qualifiers
  localparam int num_qualifiers = 3;
  localparam int qual_timer     = 0;
  localparam int qual_uart      = 1;
  localparam int qual_wdog      = 2;

  // SysTick calibration, 10 ms worth of ticks at 100 MHz
  localparam int systick_width = 24;
  localparam logic [systick_width-1:0] systick_calib_reset = 24'h0F_4240;

  localparam logic [apb_data_width-1:0] pctrl_id = 32'hA4A0_0100;

  // Register byte offsets
  localparam logic [apb_addr_width-1:0] reg_id         = 12'h000;
  localparam logic [apb_addr_width-1:0] reg_pad_ds     = 12'h004;
  localparam logic [apb_addr_width-1:0] reg_reset_ctrl = 12'h008;
  localparam logic [apb_addr_width-1:0] reg_timer_div  = 12'h00C;
  localparam logic [apb_addr_width-1:0] reg_uart_div   = 12'h010;
  localparam logic [apb_addr_width-1:0] reg_wdog_div   = 12'h014;
  localparam logic [apb_addr_width-1:0] reg_systick    = 12'h018;

  localparam int loop_sel_width = 4;

endpackage

`default_nettype wire

// File: source/reset_sync_bank.sv
/* Reset synchronizers, one per domain, asserted asynchronously by the
   pin reset or a software hold and released through a flop chain */
`timescale 1ns/1ps
`default_nettype none

module reset_sync_bank #(
  parameter int sync_stages = 2
) (
  input  logic                                  master_clk,
  input  logic                                  arst_n,
  input  logic [aha_soc_pkg::num_domains-1:0]   sw_reset_hold,
  output logic [aha_soc_pkg::num_domains-1:0]   domain_reset_n
);

  import aha_soc_pkg::*;

  // Combined clear per domain
  logic [num_domains-1:0] clr_n;

  assign clr_n = {num_domains{arst_n}} & ~sw_reset_hold;

  for (genvar d = 0; d < num_domains; d++) begin : g_dom
    logic [sync_stages-1:0] sync_q;

    always_ff @(posedge master_clk or negedge clr_n[d]) begin
      if (!clr_n[d]) begin
        sync_q <= '0;
      end else begin
        sync_q[0] <= 1'b1;
        for (int s = 1; s < sync_stages; s++) begin
          sync_q[s] <= sync_q[s-1];
        end
      end
    end

    // Last stage is the domain reset
    assign domain_reset_n[d] = sync_q[sync_stages-1];
  end

endmodule

`default_nettype wire

// File: source/clk_qualifier.sv
/* Programmable clock-enable qualifiers for timer, UART and watchdog,
   one down-counter per qualifier */
`timescale 1ns/1ps
`default_nettype none

module clk_qualifier #(
  parameter int div_width = 8
) (
  input  logic                                                  master_clk,
  input  logic                                                  arst_n,
  input  logic [aha_soc_pkg::num_qualifiers-1:0][div_width-1:0] clk_div,
  output logic [aha_soc_pkg::num_qualifiers-1:0]                clk_en
);

  import aha_soc_pkg::*;

  for (genvar q = 0; q < num_qualifiers; q++) begin : g_qual
    // Divider seen by the counter, to spot a new value
    logic [div_width-1:0] div_q;
    logic [div_width-1:0] cnt_q;

    always_ff @(posedge master_clk or negedge arst_n) begin
      if (!arst_n) begin
        div_q <= '0;
        cnt_q <= '0;
      end else if (clk_div[q] != div_q) begin
        // New divider restarts the period
        div_q <= clk_div[q];
        cnt_q <= clk_div[q];
      end else if (cnt_q == '0) begin
        cnt_q <= div_q;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    // One cycle in every div+1, constant high for div of zero
    assign clk_en[q] = (cnt_q == '0);
  end

endmodule

`default_nettype wire

// File: source/pctrl_regs.sv
/* APB register slave for the platform controller: pad drive strength,
   software reset holds, qualifier dividers and SysTick calibration */
`timescale 1ns/1ps
`default_nettype none

module pctrl_regs #(
  parameter int div_width = 8
) (
  input  logic                                                  master_clk,
  input  logic                                                  arst_n,

  // APB slave
  input  logic                                                  psel,
  input  logic                                                  penable,
  input  logic                                                  pwrite,
  input  logic [aha_soc_pkg::apb_addr_width-1:0]                paddr,
  input  logic [aha_soc_pkg::apb_data_width-1:0]                pwdata,
  output logic [aha_soc_pkg::apb_data_width-1:0]                prdata,
  output logic                                                  pready,
  output logic                                                  pslverr,

  // Register fields
  output aha_soc_pkg::pad_ds_t [aha_soc_pkg::num_pad_groups-1:0] out_pad_ds,
  output logic [aha_soc_pkg::systick_width-1:0]                 sys_tick_calib,
  output logic [aha_soc_pkg::num_domains-1:0]                   sw_reset_hold,
  output logic [aha_soc_pkg::num_qualifiers-1:0][div_width-1:0] clk_div
);

  import aha_soc_pkg::*;

  localparam int pad_bits = num_pad_groups * pad_ds_width;

  logic                      access;
  logic                      addr_hit;
  logic                      wr_en;
  logic [apb_data_width-1:0] rd_data;

  // ----------------------------------------------------------
  // Access decode
  // ----------------------------------------------------------
  assign access = psel & penable;
  assign wr_en  = access & pwrite & addr_hit;

  // No wait states
  assign pready  = 1'b1;
  assign pslverr = access & ~addr_hit;
  assign prdata  = (access && !pwrite) ? rd_data : '0;

  always_comb begin
    rd_data  = '0;
    addr_hit = 1'b1;
    case (paddr)
      reg_id:         rd_data = pctrl_id;
      reg_pad_ds:     rd_data[pad_bits-1:0] = out_pad_ds;
      reg_reset_ctrl: rd_data[num_domains-1:0] = sw_reset_hold;
      reg_timer_div:  rd_data[div_width-1:0] = clk_div[qual_timer];
      reg_uart_div:   rd_data[div_width-1:0] = clk_div[qual_uart];
      reg_wdog_div:   rd_data[div_width-1:0] = clk_div[qual_wdog];
      reg_systick:    rd_data[systick_width-1:0] = sys_tick_calib;
      default:        addr_hit = 1'b0;
    endcase
  end

  // ----------------------------------------------------------
  // Register file
  // ----------------------------------------------------------
  always_ff @(posedge master_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_pad_ds     <= {num_pad_groups{pad_ds_reset}};
      sys_tick_calib <= systick_calib_reset;
      sw_reset_hold  <= '0;
      clk_div        <= '0;
    end else if (wr_en) begin
      // reg_id is read only and falls through
      case (paddr)
        reg_pad_ds:     out_pad_ds <= pwdata[pad_bits-1:0];
        reg_reset_ctrl: sw_reset_hold <= pwdata[num_domains-1:0];
        reg_timer_div:  clk_div[qual_timer] <= pwdata[div_width-1:0];
        reg_uart_div:   clk_div[qual_uart] <= pwdata[div_width-1:0];
        reg_wdog_div:   clk_div[qual_wdog] <= pwdata[div_width-1:0];
        reg_systick:    sys_tick_calib <= pwdata[systick_width-1:0];
        default:        ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/loop_back_gen.sv
/* Registered loop-back selector over the clock qualifiers and the
   domain resets */
`timescale 1ns/1ps
`default_nettype none

module loop_back_gen (
  input  logic                                     master_clk,
  input  logic                                     arst_n,
  input  logic [aha_soc_pkg::loop_sel_width-1:0]   loop_back_select,
  input  logic [aha_soc_pkg::num_qualifiers-1:0]   clk_en,
  input  logic [aha_soc_pkg::num_domains-1:0]      domain_reset_n,
  output logic                                     loop_back
);

  import aha_soc_pkg::*;

  logic loop_back_nxt;

  // Qualifiers first, domain resets after them
  always_comb begin
    case (loop_back_select)
      qual_timer:                  loop_back_nxt = clk_en[qual_timer];
      qual_uart:                   loop_back_nxt = clk_en[qual_uart];
      qual_wdog:                   loop_back_nxt = clk_en[qual_wdog];
      num_qualifiers + dom_cpu:    loop_back_nxt = domain_reset_n[dom_cpu];
      num_qualifiers + dom_periph: loop_back_nxt = domain_reset_n[dom_periph];
      num_qualifiers + dom_tlx:    loop_back_nxt = domain_reset_n[dom_tlx];
      num_qualifiers + dom_cgra:   loop_back_nxt = domain_reset_n[dom_cgra];
      default:                     loop_back_nxt = 1'b0;
    endcase
  end

  always_ff @(posedge master_clk or negedge arst_n) begin
    if (!arst_n) begin
      loop_back <= 1'b0;
    end else begin
      loop_back <= loop_back_nxt;
    end
  end

endmodule

`default_nettype wire

// File: source/aha_platform_ctrl.sv
/* Platform controller top level: register slave, reset synchronizers,
   clock qualifiers and loop-back generator */
`timescale 1ns/1ps
`default_nettype none

module aha_platform_ctrl #(
  parameter int sync_stages = 2,
  parameter int div_width   = 8
) (
  // Master clock and power-on reset
  input  logic                                                  master_clk,
  input  logic                                                  arst_n,

  // APB register port
  input  logic                                                  psel,
  input  logic                                                  penable,
  input  logic                                                  pwrite,
  input  logic [aha_soc_pkg::apb_addr_width-1:0]                paddr,
  input  logic [aha_soc_pkg::apb_data_width-1:0]                pwdata,
  output logic [aha_soc_pkg::apb_data_width-1:0]                prdata,
  output logic                                                  pready,
  output logic                                                  pslverr,

  // Pad strength and SysTick
  output aha_soc_pkg::pad_ds_t [aha_soc_pkg::num_pad_groups-1:0] out_pad_ds,
  output logic [aha_soc_pkg::systick_width-1:0]                 sys_tick_calib,

  // Domain resets and clock qualifiers
  output logic [aha_soc_pkg::num_domains-1:0]                   domain_reset_n,
  output logic [aha_soc_pkg::num_qualifiers-1:0]                clk_en,

  // Loop-back pin
  input  logic [aha_soc_pkg::loop_sel_width-1:0]                loop_back_select,
  output logic                                                  loop_back
);

  import aha_soc_pkg::*;

  logic [num_domains-1:0]                   sw_reset_hold;
  logic [num_qualifiers-1:0][div_width-1:0] clk_div;

  // ----------------------------------------------------------
  // Register slave
  // ----------------------------------------------------------
  pctrl_regs #(
    .div_width        (div_width)
  ) i_pctrl_regs (
    .master_clk       (master_clk),
    .arst_n           (arst_n),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pready           (pready),
    .pslverr          (pslverr),
    .out_pad_ds       (out_pad_ds),
    .sys_tick_calib   (sys_tick_calib),
    .sw_reset_hold    (sw_reset_hold),
    .clk_div          (clk_div)
  );

  // ----------------------------------------------------------
  // Resets and qualifiers
  // ----------------------------------------------------------
  reset_sync_bank #(
    .sync_stages      (sync_stages)
  ) i_reset_sync_bank (
    .master_clk       (master_clk),
    .arst_n           (arst_n),
    .sw_reset_hold    (sw_reset_hold),
    .domain_reset_n   (domain_reset_n)
  );

  clk_qualifier #(
    .div_width        (div_width)
  ) i_clk_qualifier (
    .master_clk       (master_clk),
    .arst_n           (arst_n),
    .clk_div          (clk_div),
    .clk_en           (clk_en)
  );

  // ----------------------------------------------------------
  // Loop-back observation
  // ----------------------------------------------------------
  loop_back_gen i_loop_back_gen (
    .master_clk       (master_clk),
    .arst_n           (arst_n),
    .loop_back_select (loop_back_select),
    .clk_en           (clk_en),
    .domain_reset_n   (domain_reset_n),
    .loop_back        (loop_back)
  );

endmodule

`default_nettype wire

// File: sim/aha_platform_ctrl_properties.sv
/* Concurrent assertions on the platform controller ports, bound to
   the top level */
`timescale 1ns/1ps
`default_nettype none

module aha_platform_ctrl_properties (
  input logic                                  master_clk,
  input logic                                  arst_n,
  input logic                                  psel,
  input logic                                  penable,
  input logic                                  pslverr,
  input logic [aha_soc_pkg::num_domains-1:0]   domain_reset_n,
  input logic [aha_soc_pkg::loop_sel_width-1:0] loop_back_select,
  input logic                                  loop_back
);

  import aha_soc_pkg::*;

  // Number of failed assertions
  int fail_count = 0;

  // Slave error only in an access phase
  slverr_in_access: assert property (@(posedge master_clk) pslverr |-> (psel && penable))
    else begin
      $error("pslverr high outside an access phase");
      fail_count++;
    end

  domains_held_in_reset: assert property (@(posedge master_clk) !arst_n |-> domain_reset_n == '0)
    else begin
      $error("domain reset released while arst_n low");
      fail_count++;
    end

  // Unused select codes
  loop_back_unused_zero: assert property (@(posedge master_clk) disable iff (!arst_n)
    (loop_back_select >= num_qualifiers + num_domains) |=> !loop_back)
    else begin
      $error("loop_back high after an unused select code");
      fail_count++;
    end

endmodule

bind aha_platform_ctrl aha_platform_ctrl_properties i_properties (.*);

`default_nettype wire

// File: sim/tb_aha_platform_ctrl.sv
/* Testbench for the platform controller: clock and reset, APB tasks,
   directed tests and the closing summary */
`timescale 1ns/1ps
`default_nettype none

module tb_aha_platform_ctrl;

  import aha_soc_pkg::*;

  localparam int sync_stages     = 2;
  localparam int div_width       = 8;
  localparam int apb_timeout     = 16;
  localparam int release_timeout = sync_stages + 8;
  localparam int pad_bits        = num_pad_groups * pad_ds_width;

  localparam logic [apb_addr_width-1:0] div_offset [num_qualifiers] =
    '{reg_timer_div, reg_uart_div, reg_wdog_div};

  logic                                 master_clk;
  logic                                 arst_n;
  logic                                 psel;
  logic                                 penable;
  logic                                 pwrite;
  logic [apb_addr_width-1:0]            paddr;
  logic [apb_data_width-1:0]            pwdata;
  logic [apb_data_width-1:0]            prdata;
  logic                                 pready;
  logic                                 pslverr;
  pad_ds_t [num_pad_groups-1:0]         out_pad_ds;
  logic [systick_width-1:0]             sys_tick_calib;
  logic [num_domains-1:0]               domain_reset_n;
  logic [num_qualifiers-1:0]            clk_en;
  logic [loop_sel_width-1:0]            loop_back_select;
  logic                                 loop_back;

  int errors;
  int checks;

  aha_platform_ctrl #(
    .sync_stages      (sync_stages),
    .div_width        (div_width)
  ) i_aha_platform_ctrl (
    .master_clk       (master_clk),
    .arst_n           (arst_n),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pready           (pready),
    .pslverr          (pslverr),
    .out_pad_ds       (out_pad_ds),
    .sys_tick_calib   (sys_tick_calib),
    .domain_reset_n   (domain_reset_n),
    .clk_en           (clk_en),
    .loop_back_select (loop_back_select),
    .loop_back        (loop_back)
  );

  initial begin
    master_clk = 1'b0;
    forever #20 master_clk = ~master_clk;
  end

  // ----------------------------------------------------------
  // Checks and reporting
  // ----------------------------------------------------------
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %s finished with %0d errors", name, errors - errors_before);
  endtask

  // ----------------------------------------------------------
  // APB master
  // ----------------------------------------------------------
  task automatic apb_access(input logic write, input logic [apb_addr_width-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    waited = 0;
    @(posedge master_clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge master_clk);
    #1;
    penable = 1'b1;
    #5;
    while (!pready && waited < apb_timeout) begin
      @(posedge master_clk);
      #6;
      waited++;
    end
    expect_true(pready, "APB transfer timed out waiting for pready");
    rdata = prdata;
    err   = pslverr;
    // Transfer completes on this edge
    @(posedge master_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [apb_addr_width-1:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [apb_addr_width-1:0] addr, output logic [31:0] data,
                          output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  task automatic wait_resets_released(output int cycles);
    cycles = 0;
    while (domain_reset_n != '1 && cycles < release_timeout) begin
      @(posedge master_clk);
      #1;
      cycles++;
    end
    expect_true(domain_reset_n == '1, "domain resets were never released");
  endtask

  // Source picked by each loop-back select code
  function automatic logic expected_loop_back(input int code, input logic [2:0] en,
                                              input logic [3:0] rst_n);
    if (code < num_qualifiers) begin
      return en[code];
    end
    if (code < num_qualifiers + num_domains) begin
      return rst_n[code - num_qualifiers];
    end
    return 1'b0;
  endfunction

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic reset_values();
    int start;
    int cycles;
    logic [31:0] rdata;
    logic [31:0] exp_pad;
    logic err;
    start   = errors;
    exp_pad = '0;
    for (int g = 0; g < num_pad_groups; g++) begin
      exp_pad[g*pad_ds_width +: pad_ds_width] = pad_ds_reset;
    end
    compare_value("prdata", prdata, 32'h0);
    compare_value("pslverr", pslverr, 1'b0);
    wait_resets_released(cycles);
    compare_value("clk_en", clk_en, 3'b111);
    compare_value("out_pad_ds", out_pad_ds, exp_pad);
    compare_value("sys_tick_calib", sys_tick_calib, systick_calib_reset);
    apb_read(reg_id, rdata, err);
    compare_value("prdata", rdata, pctrl_id);
    compare_value("pslverr", err, 1'b0);
    apb_read(reg_pad_ds, rdata, err);
    compare_value("prdata", rdata, exp_pad);
    apb_read(reg_systick, rdata, err);
    compare_value("prdata", rdata, systick_calib_reset);
    report_test("reset_values", start);
  endtask

  task automatic register_access();
    int start;
    logic [31:0] value;
    logic [31:0] rdata;
    logic [31:0] pad_mask;
    logic err;
    start    = errors;
    pad_mask = (32'h1 << pad_bits) - 1;
    value    = $urandom;
    apb_write(reg_pad_ds, value, err);
    compare_value("pslverr", err, 1'b0);
    apb_read(reg_pad_ds, rdata, err);
    compare_value("prdata", rdata, value & pad_mask);
    compare_value("out_pad_ds", out_pad_ds, value & pad_mask);
    value = $urandom;
    apb_write(reg_systick, value, err);
    apb_read(reg_systick, rdata, err);
    compare_value("prdata", rdata, value & ((32'h1 << systick_width) - 1));
    compare_value("sys_tick_calib", sys_tick_calib, value[systick_width-1:0]);
    // Read-only identification word
    apb_write(reg_id, $urandom, err);
    compare_value("pslverr", err, 1'b0);
    apb_read(reg_id, rdata, err);
    compare_value("prdata", rdata, pctrl_id);
    // Unmapped offsets
    apb_write(12'h01C, $urandom, err);
    compare_value("pslverr", err, 1'b1);
    apb_read(12'h01C, rdata, err);
    compare_value("prdata", rdata, 32'h0);
    compare_value("pslverr", err, 1'b1);
    apb_read(12'h800, rdata, err);
    compare_value("pslverr", err, 1'b1);
    report_test("register_access", start);
  endtask

  task automatic software_reset();
    int start;
    int cycles;
    logic [31:0] rdata;
    logic [3:0] exp_rst;
    logic err;
    start = errors;
    for (int d = 0; d < num_domains; d++) begin
      exp_rst = 4'hF & ~(4'h1 << d);
      apb_write(reg_reset_ctrl, 32'h1 << d, err);
      compare_value("domain_reset_n", domain_reset_n, exp_rst);
      apb_read(reg_reset_ctrl, rdata, err);
      compare_value("prdata", rdata, 32'h1 << d);
      apb_write(reg_reset_ctrl, 32'h0, err);
      wait_resets_released(cycles);
      expect_true(cycles <= sync_stages + 1, "domain reset released too late");
    end
    report_test("software_reset", start);
  endtask

  task automatic clock_qualifiers();
    int start;
    int d;
    int pulses;
    int last;
    logic [31:0] rdata;
    logic err;
    start = errors;
    for (int q = 0; q < num_qualifiers; q++) begin
      d = 1 + ($urandom % 7);
      apb_write(div_offset[q], d, err);
      apb_read(div_offset[q], rdata, err);
      compare_value("prdata", rdata, d);
      pulses = 0;
      last   = -1;
      for (int c = 0; c < 4 * (d + 1); c++) begin
        @(posedge master_clk);
        #1;
        if (clk_en[q]) begin
          if (last >= 0) begin
            compare_value("clk_en pulse spacing", c - last, d + 1);
          end
          last = c;
          pulses++;
        end
      end
      compare_value("clk_en pulse count", pulses, 4);
    end
    report_test("clock_qualifiers", start);
  endtask

  task automatic loop_back_sweep();
    int start;
    int cycles;
    logic exp;
    logic err;
    start = errors;
    // Hold periph and cgra so the reset sources differ
    apb_write(reg_reset_ctrl, 32'hA, err);
    for (int code = 0; code < 16; code++) begin
      loop_back_select = code[loop_sel_width-1:0];
      // A full qualifier period, so both levels are seen
      for (int c = 0; c < 8; c++) begin
        exp = expected_loop_back(code, clk_en, domain_reset_n);
        @(posedge master_clk);
        #1;
        compare_value("loop_back", loop_back, exp);
      end
    end
    apb_write(reg_reset_ctrl, 32'h0, err);
    wait_resets_released(cycles);
    report_test("loop_back_sweep", start);
  endtask

  initial begin
    void'($urandom(1));
    errors           = 0;
    checks           = 0;
    arst_n           = 1'b0;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    paddr            = '0;
    pwdata           = '0;
    loop_back_select = '0;
    repeat (10) @(posedge master_clk);
    #1;
    arst_n = 1'b1;
    reset_values();
    register_access();
    software_reset();
    clock_qualifiers();
    loop_back_sweep();
    errors += i_aha_platform_ctrl.i_properties.fail_count;
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/aha_soc_pkg.sv
source/reset_sync_bank.sv
source/clk_qualifier.sv
source/pctrl_regs.sv
source/loop_back_gen.sv
source/aha_platform_ctrl.sv
sim/aha_platform_ctrl_properties.sv
sim/tb_aha_platform_ctrl.sv
